// ==== hdl/pipe_scene_pkg.sv ====
package pipe_scene_pkg;

    // --------------------
    // Shared types
    // --------------------

    // Colour as {red, green, blue}
    typedef logic [23:0] rgb_t;

    // Signed so pipes can sit off-screen on either side
    typedef logic signed [15:0] coord_t;

    typedef logic [15:0] lfsr_t;

    // --------------------
    // Gap randomiser
    // --------------------

    // Must never be zero
    localparam lfsr_t LFSR_SEED = 16'hACE1;

    // Maximal-length taps 16, 14, 13, 11
    function automatic lfsr_t lfsr_next(input lfsr_t s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // --------------------
    // Pipe shading
    // --------------------
    localparam int PIPE_OUTLINE_W = 2;
    localparam int PIPE_HILITE_W  = 4;

    localparam rgb_t PIPE_COLOUR = 24'h30_D0_30;
    localparam rgb_t PIPE_DARK   = 24'h1F_A0_1F;
    localparam rgb_t PIPE_LIGHT  = 24'h6A_F0_6A;

    // --------------------
    // Background
    // --------------------
    localparam rgb_t GRASS_COLOUR  = 24'h2E_8B_57;
    localparam rgb_t GROUND_COLOUR = 24'h8B_45_13;

    // Sky keeps red and green fixed, blue fades with y
    localparam logic [7:0] SKY_RED   = 8'd135;
    localparam logic [7:0] SKY_GREEN = 8'd206;
    localparam int SKY_BLUE_TOP = 220;
    localparam int SKY_BLUE_MIN = 120;

endpackage

// ==== hdl/raster_counter.sv ====
module raster_counter #(
    parameter int FRAME_W = 1920,
    parameter int FRAME_H = 1080
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   cen_i,
    input  logic [1:0]             vh_blank_i,
    input  logic [2:0]             dvh_sync_i,
    output pipe_scene_pkg::coord_t x_o,
    output pipe_scene_pkg::coord_t y_o,
    output logic                   active_o,
    output logic                   frame_start_o
);
    import pipe_scene_pkg::*;

    // Previous sync levels for edge detection
    logic   hsync_q;
    logic   vsync_q;
    logic   hsync_rise;
    logic   vsync_rise;

    // Active-picture position
    coord_t x_q;
    coord_t y_q;

    // Sync history follows every clock, not only enabled ones
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            hsync_q <= 1'b0;
            vsync_q <= 1'b0;
        end else begin
            hsync_q <= dvh_sync_i[0];
            vsync_q <= dvh_sync_i[1];
        end
    end

    // One-cycle pulses while the sync level rises
    assign hsync_rise = dvh_sync_i[0] & ~hsync_q;
    assign vsync_rise = dvh_sync_i[1] & ~vsync_q;

    // Pixel is visible when neither blanking bit is set
    assign active_o      = (vh_blank_i == 2'b00);
    assign frame_start_o = vsync_rise;

    // --------------------
    // Coordinate counters
    // --------------------
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            x_q <= '0;
            y_q <= '0;
        end else if (cen_i) begin
            if (vsync_rise) begin
                x_q <= '0;
                y_q <= '0;
            end else if (hsync_rise) begin
                // New line, y stops at the last row
                x_q <= '0;
                if (y_q < coord_t'(FRAME_H - 1)) begin
                    y_q <= y_q + coord_t'(1);
                end
            end else if (active_o && (x_q < coord_t'(FRAME_W - 1))) begin
                x_q <= x_q + coord_t'(1);
            end
        end
    end

    assign x_o = x_q;
    assign y_o = y_q;

endmodule

// ==== hdl/pipe_scroller.sv ====
module pipe_scroller #(
    parameter int FRAME_W      = 1920,
    parameter int FRAME_H      = 1080,
    parameter int NUM_PIPES    = 4,
    parameter int PIPE_WIDTH   = 90,
    parameter int GAP_HEIGHT   = 240,
    parameter int GAP_MARGIN   = 80,
    parameter int PIPE_SPACING = 520,
    parameter int START_OFFSET = 200,
    parameter int SPEED_SLOW   = 4,
    parameter int SPEED_FAST   = 8,
    parameter int RAND_BITS    = 10,
    parameter int GAP_INIT [NUM_PIPES] = '{default: 0}
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   cen_i,
    input  logic                   fast_i,
    input  logic                   frame_start_i,
    output pipe_scene_pkg::coord_t pipe_x_o [NUM_PIPES],
    output pipe_scene_pkg::coord_t gap_y_o  [NUM_PIPES]
);
    import pipe_scene_pkg::*;

    // Number of legal gap tops above the margin
    localparam int GAP_RANGE = FRAME_H - GAP_HEIGHT - 2 * GAP_MARGIN + 1;

    // --------------------
    // Registered pipe state
    // --------------------

    // Left edge of each pipe column
    coord_t pipe_x_q [NUM_PIPES];
    // Top row of each gap
    coord_t gap_y_q  [NUM_PIPES];
    lfsr_t  lfsr_q;

    // Next-frame values
    coord_t pipe_x_d [NUM_PIPES];
    coord_t gap_y_d  [NUM_PIPES];
    lfsr_t  lfsr_d;

    // Working values for one frame step
    coord_t next_x   [NUM_PIPES];
    coord_t step;
    coord_t base_x;
    lfsr_t  lfsr_walk;

    // Initial column of pipe idx, lined up beyond the right edge
    function automatic coord_t start_x(input int idx);
        return coord_t'(FRAME_W + START_OFFSET + idx * PIPE_SPACING);
    endfunction

    // Low LFSR bits folded into the gap range by repeated subtraction
    // Three passes are enough while 4 * range exceeds 2^RAND_BITS
    function automatic coord_t gap_from_lfsr(input lfsr_t s);
        int v;
        v = int'(s[RAND_BITS-1:0]);
        for (int k = 0; k < 3; k++) begin
            if (v >= GAP_RANGE) begin
                v = v - GAP_RANGE;
            end
        end
        return coord_t'(GAP_MARGIN + v);
    endfunction

    // --------------------
    // Frame step
    // --------------------
    always_comb begin
        step = fast_i ? coord_t'(SPEED_FAST) : coord_t'(SPEED_SLOW);

        // LFSR moves once per frame even with no wrap
        lfsr_walk = lfsr_next(lfsr_q);

        for (int i = 0; i < NUM_PIPES; i++) begin
            next_x[i] = pipe_x_q[i] - step;
        end

        // Rightmost pipe after the move
        base_x = next_x[0];
        for (int i = 1; i < NUM_PIPES; i++) begin
            if (next_x[i] > base_x) begin
                base_x = next_x[i];
            end
        end

        // Pipes that left the screen go behind the rightmost one
        // Base grows with each wrap so two wraps never land together
        for (int i = 0; i < NUM_PIPES; i++) begin
            if ((next_x[i] + coord_t'(PIPE_WIDTH)) <= coord_t'(0)) begin
                base_x      = base_x + coord_t'(PIPE_SPACING);
                pipe_x_d[i] = base_x;
                lfsr_walk   = lfsr_next(lfsr_walk);
                gap_y_d[i]  = gap_from_lfsr(lfsr_walk);
            end else begin
                pipe_x_d[i] = next_x[i];
                gap_y_d[i]  = gap_y_q[i];
            end
        end

        lfsr_d = lfsr_walk;
    end

    // State moves only on an enabled frame start
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            lfsr_q <= LFSR_SEED;
            for (int i = 0; i < NUM_PIPES; i++) begin
                pipe_x_q[i] <= start_x(i);
                gap_y_q[i]  <= coord_t'(GAP_INIT[i]);
            end
        end else if (cen_i && frame_start_i) begin
            lfsr_q   <= lfsr_d;
            pipe_x_q <= pipe_x_d;
            gap_y_q  <= gap_y_d;
        end
    end

    assign pipe_x_o = pipe_x_q;
    assign gap_y_o  = gap_y_q;

endmodule

// ==== hdl/pixel_composer.sv ====
module pixel_composer #(
    parameter int FRAME_H       = 1080,
    parameter int NUM_PIPES     = 4,
    parameter int PIPE_WIDTH    = 90,
    parameter int GAP_HEIGHT    = 240,
    parameter int GRASS_HEIGHT  = 80,
    parameter int GROUND_HEIGHT = 40
) (
    input  logic                   clk,
    input  logic                   rst_i,
    input  logic                   cen_i,
    input  pipe_scene_pkg::coord_t x_i,
    input  pipe_scene_pkg::coord_t y_i,
    input  logic                   active_i,
    input  pipe_scene_pkg::coord_t pipe_x_i [NUM_PIPES],
    input  pipe_scene_pkg::coord_t gap_y_i  [NUM_PIPES],
    input  logic [2:0]             dvh_sync_i,
    output logic [2:0]             dvh_sync_o,
    output pipe_scene_pkg::rgb_t   vid_rgb_o
);
    import pipe_scene_pkg::*;

    // Background band limits
    localparam int GRASS_TOP  = FRAME_H - GRASS_HEIGHT - GROUND_HEIGHT;
    localparam int GROUND_TOP = FRAME_H - GROUND_HEIGHT;

    // Hit test results
    logic   pipe_hit;
    logic   in_col;
    logic   in_gap;
    coord_t col_x;
    coord_t local_x;

    rgb_t   pipe_pixel;
    rgb_t   bg_pixel;
    int     blue_val;

    // Output stage
    rgb_t       rgb_q;
    logic [2:0] sync_q;

    // --------------------
    // Pipe hit test
    // --------------------
    always_comb begin
        pipe_hit = 1'b0;
        local_x  = '0;
        in_col   = 1'b0;
        in_gap   = 1'b0;
        col_x    = '0;
        for (int i = 0; i < NUM_PIPES; i++) begin
            // Offset of this pixel from the pipe's left edge
            col_x  = x_i - pipe_x_i[i];
            in_col = (col_x >= coord_t'(0)) && (col_x < coord_t'(PIPE_WIDTH));
            in_gap = (y_i >= gap_y_i[i]) && (y_i < gap_y_i[i] + coord_t'(GAP_HEIGHT));
            // Lowest index wins where pipes overlap
            if (active_i && in_col && !in_gap && !pipe_hit) begin
                pipe_hit = 1'b1;
                local_x  = col_x;
            end
        end
    end

    // Outline on both sides, highlight strip inside the left outline
    always_comb begin
        if ((local_x < coord_t'(PIPE_OUTLINE_W)) ||
            (local_x >= coord_t'(PIPE_WIDTH - PIPE_OUTLINE_W))) begin
            pipe_pixel = PIPE_DARK;
        end else if (local_x < coord_t'(PIPE_OUTLINE_W + PIPE_HILITE_W)) begin
            pipe_pixel = PIPE_LIGHT;
        end else begin
            pipe_pixel = PIPE_COLOUR;
        end
    end

    // --------------------
    // Background
    // --------------------
    always_comb begin
        // Blue drops one step every eight rows
        blue_val = SKY_BLUE_TOP - (int'(y_i) >>> 3);
        if (blue_val < SKY_BLUE_MIN) begin
            blue_val = SKY_BLUE_MIN;
        end
        bg_pixel = {SKY_RED, SKY_GREEN, blue_val[7:0]};

        // Ground is checked last so it covers the grass band below it
        if (y_i >= coord_t'(GRASS_TOP)) begin
            bg_pixel = GRASS_COLOUR;
        end
        if (y_i >= coord_t'(GROUND_TOP)) begin
            bg_pixel = GROUND_COLOUR;
        end
    end

    // --------------------
    // One-cycle output stage
    // --------------------
    always_ff @(posedge clk or posedge rst_i) begin
        if (rst_i) begin
            rgb_q  <= '0;
            sync_q <= '0;
        end else if (cen_i) begin
            rgb_q  <= pipe_hit ? pipe_pixel : bg_pixel;
            sync_q <= dvh_sync_i;
        end
    end

    assign vid_rgb_o  = rgb_q;
    assign dvh_sync_o = sync_q;

endmodule

// ==== hdl/pipe_scene_top.sv ====
module pipe_scene_top #(
    parameter int FRAME_W       = 1920,
    parameter int FRAME_H       = 1080,
    parameter int NUM_PIPES     = 4,
    parameter int PIPE_WIDTH    = 90,
    parameter int GAP_HEIGHT    = 240,
    parameter int GAP_MARGIN    = 80,
    parameter int PIPE_SPACING  = 520,
    parameter int START_OFFSET  = 200,
    parameter int SPEED_SLOW    = 4,
    parameter int SPEED_FAST    = 8,
    parameter int RAND_BITS     = 10,
    parameter int GRASS_HEIGHT  = 80,
    parameter int GROUND_HEIGHT = 40,
    parameter int GAP_INIT [NUM_PIPES] = '{300, 520, 220, 460}
) (
    input  logic                 clk,
    input  logic                 rst_i,
    input  logic                 cen_i,
    input  logic                 fast_i,
    input  logic [1:0]           vh_blank_i,
    input  logic [2:0]           dvh_sync_i,
    output logic [2:0]           dvh_sync_o,
    output pipe_scene_pkg::rgb_t vid_rgb_o
);
    import pipe_scene_pkg::*;

    // Raster position of the current pixel
    coord_t x;
    coord_t y;
    logic   active;
    logic   frame_start;

    // Pipe layout for the current frame
    coord_t pipe_x [NUM_PIPES];
    coord_t gap_y  [NUM_PIPES];

    // Position tracking from the incoming timing
    raster_counter #(
        .FRAME_W (FRAME_W),
        .FRAME_H (FRAME_H)
    ) u_raster_counter (
        .clk           (clk),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .vh_blank_i    (vh_blank_i),
        .dvh_sync_i    (dvh_sync_i),
        .x_o           (x),
        .y_o           (y),
        .active_o      (active),
        .frame_start_o (frame_start)
    );

    // Per-frame pipe motion
    pipe_scroller #(
        .FRAME_W      (FRAME_W),
        .FRAME_H      (FRAME_H),
        .NUM_PIPES    (NUM_PIPES),
        .PIPE_WIDTH   (PIPE_WIDTH),
        .GAP_HEIGHT   (GAP_HEIGHT),
        .GAP_MARGIN   (GAP_MARGIN),
        .PIPE_SPACING (PIPE_SPACING),
        .START_OFFSET (START_OFFSET),
        .SPEED_SLOW   (SPEED_SLOW),
        .SPEED_FAST   (SPEED_FAST),
        .RAND_BITS    (RAND_BITS),
        .GAP_INIT     (GAP_INIT)
    ) u_pipe_scroller (
        .clk           (clk),
        .rst_i         (rst_i),
        .cen_i         (cen_i),
        .fast_i        (fast_i),
        .frame_start_i (frame_start),
        .pipe_x_o      (pipe_x),
        .gap_y_o       (gap_y)
    );

    // Colour and sync, one cycle late
    pixel_composer #(
        .FRAME_H       (FRAME_H),
        .NUM_PIPES     (NUM_PIPES),
        .PIPE_WIDTH    (PIPE_WIDTH),
        .GAP_HEIGHT    (GAP_HEIGHT),
        .GRASS_HEIGHT  (GRASS_HEIGHT),
        .GROUND_HEIGHT (GROUND_HEIGHT)
    ) u_pixel_composer (
        .clk        (clk),
        .rst_i      (rst_i),
        .cen_i      (cen_i),
        .x_i        (x),
        .y_i        (y),
        .active_i   (active),
        .pipe_x_i   (pipe_x),
        .gap_y_i    (gap_y),
        .dvh_sync_i (dvh_sync_i),
        .dvh_sync_o (dvh_sync_o),
        .vid_rgb_o  (vid_rgb_o)
    );

endmodule

// ==== testbench/pipe_scene_sva.sv ====
module pipe_scene_sva (
    input logic        clk,
    input logic        rst_i,
    input logic        cen_i,
    input logic [2:0]  dvh_sync_i,
    input logic [2:0]  sync_out_i,
    input logic [23:0] rgb_out_i
);
    timeunit 1ns;
    timeprecision 1ps;

    // Sync comes out one enabled cycle after it went in
    assert property (@(posedge clk) disable iff (rst_i)
        cen_i |=> (sync_out_i == $past(dvh_sync_i)))
        else $error("sync output does not match the enabled input of the previous cycle");

    // Output stage holds without an enable
    assert property (@(posedge clk) disable iff (rst_i)
        !cen_i |=> ($stable(sync_out_i) && $stable(rgb_out_i)))
        else $error("outputs changed while the clock enable was low");

    // A clock under reset leaves both outputs cleared
    assert property (@(posedge clk)
        rst_i |=> ((sync_out_i == 3'b000) && (rgb_out_i == 24'h0)))
        else $error("outputs not cleared by reset");

endmodule

bind pipe_scene_top pipe_scene_sva u_pipe_scene_sva (
    .clk        (clk),
    .rst_i      (rst_i),
    .cen_i      (cen_i),
    .dvh_sync_i (dvh_sync_i),
    .sync_out_i (dvh_sync_o),
    .rgb_out_i  (vid_rgb_o)
);

// ==== testbench/tb_scene_model.svh ====
`ifndef TB_SCENE_MODEL_SVH
`define TB_SCENE_MODEL_SVH

// --------------------
// Reference model state
// --------------------
logic        m_hs_q;
logic        m_vs_q;
int          m_x;
int          m_y;
int          m_px [NUM_PIPES];
int          m_gy [NUM_PIPES];
logic [15:0] m_lfsr;
logic [2:0]  exp_sync;
logic [23:0] exp_rgb;
// Coverage counters, kept across resets
int          wraps_seen = 0;
int          pipe_pixels_seen = 0;

// Shift left, feedback from bits 15, 13, 12 and 10
function automatic logic [15:0] lfsr_step(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
endfunction

// Gap top is the margin plus the low bits taken modulo the legal range
function automatic int gap_top(input logic [15:0] s);
    int range;
    range = FRAME_H - GAP_HEIGHT - 2 * GAP_MARGIN + 1;
    return GAP_MARGIN + (int'(s[RAND_BITS-1:0]) % range);
endfunction

task automatic model_reset();
    m_hs_q   = 1'b0;
    m_vs_q   = 1'b0;
    m_x      = 0;
    m_y      = 0;
    m_lfsr   = 16'hACE1;
    exp_sync = 3'b000;
    exp_rgb  = 24'h0;
    for (int i = 0; i < NUM_PIPES; i++) begin
        m_px[i] = FRAME_W + START_OFFSET + i * PIPE_SPACING;
        m_gy[i] = GAP_INIT[i];
    end
endtask

// Colour of one pixel from the current pipe layout
task automatic pick_colour(input int x, input int y, input logic act,
                           output logic [23:0] c, output logic hit);
    int lx;
    int blue;
    hit = 1'b0;
    // Sky fades with depth, then grass, ground on the bottom rows
    blue = SKY_BLUE_TOP - y / 8;
    if (blue < SKY_BLUE_MIN) begin
        blue = SKY_BLUE_MIN;
    end
    c = {SKY_RED, SKY_GREEN, 8'(blue)};
    if (y >= FRAME_H - GROUND_HEIGHT) begin
        c = GROUND_COLOUR;
    end else if (y >= FRAME_H - GRASS_HEIGHT - GROUND_HEIGHT) begin
        c = GRASS_COLOUR;
    end
    for (int i = NUM_PIPES - 1; i >= 0; i--) begin
        lx = x - m_px[i];
        // Walk downwards so the lowest index ends up on top
        if (act && lx >= 0 && lx < PIPE_WIDTH && !(y >= m_gy[i] && y < m_gy[i] + GAP_HEIGHT)) begin
            hit = 1'b1;
            if (lx < 2 || lx >= PIPE_WIDTH - 2) begin
                c = PIPE_DARK;
            end else if (lx < 6) begin
                c = PIPE_LIGHT;
            end else begin
                c = PIPE_COLOUR;
            end
        end
    end
endtask

// --------------------
// Frame step
// --------------------
task automatic model_frame_step(input logic fast);
    int nx [NUM_PIPES];
    int base;
    m_lfsr = lfsr_step(m_lfsr);
    for (int i = 0; i < NUM_PIPES; i++) begin
        nx[i] = m_px[i] - (fast ? SPEED_FAST : SPEED_SLOW);
    end
    base = nx[0];
    for (int i = 1; i < NUM_PIPES; i++) begin
        base = (nx[i] > base) ? nx[i] : base;
    end
    for (int i = 0; i < NUM_PIPES; i++) begin
        if (nx[i] + PIPE_WIDTH <= 0) begin
            // Each wrap lands one spacing past the previous one
            base    = base + PIPE_SPACING;
            m_px[i] = base;
            m_lfsr  = lfsr_step(m_lfsr);
            m_gy[i] = gap_top(m_lfsr);
            wraps_seen++;
        end else begin
            m_px[i] = nx[i];
        end
    end
endtask

// One rising clock edge seen with the inputs of that cycle
task automatic model_clock(input logic rst, input logic cen, input logic fast,
                           input logic [1:0] blank, input logic [2:0] sync);
    logic hs_rise;
    logic vs_rise;
    logic act;
    logic hit;
    logic [23:0] c;
    if (rst) begin
        model_reset();
    end else begin
        hs_rise = sync[0] & ~m_hs_q;
        vs_rise = sync[1] & ~m_vs_q;
        act     = (blank == 2'b00);
        if (cen) begin
            // Colour uses the layout from before this edge
            pick_colour(m_x, m_y, act, c, hit);
            exp_rgb  = c;
            exp_sync = sync;
            pipe_pixels_seen += hit;
            if (vs_rise) begin
                model_frame_step(fast);
                m_x = 0;
                m_y = 0;
            end else if (hs_rise) begin
                m_x = 0;
                m_y = (m_y < FRAME_H - 1) ? m_y + 1 : m_y;
            end else if (act && m_x < FRAME_W - 1) begin
                m_x++;
            end
        end
        // Edge history runs on every clock
        m_hs_q = sync[0];
        m_vs_q = sync[1];
    end
endtask

`endif

// ==== testbench/tb_pipe_scene.sv ====
module tb_pipe_scene;
    timeunit 1ns;
    timeprecision 1ps;
    import pipe_scene_pkg::*;

    // Small frame so one run sees several wraps
    localparam int FRAME_W       = 160;
    localparam int FRAME_H       = 90;
    localparam int NUM_PIPES     = 4;
    localparam int PIPE_WIDTH    = 16;
    localparam int GAP_HEIGHT    = 30;
    localparam int GAP_MARGIN    = 10;
    localparam int PIPE_SPACING  = 60;
    localparam int START_OFFSET  = 20;
    localparam int SPEED_SLOW    = 4;
    localparam int SPEED_FAST    = 8;
    localparam int RAND_BITS     = 7;
    localparam int GRASS_HEIGHT  = 12;
    localparam int GROUND_HEIGHT = 6;
    localparam int GAP_INIT [NUM_PIPES] = '{20, 40, 15, 35};

    // Line is back porch, active pixels, then hsync
    localparam int H_BACK      = 2;
    localparam int H_SYNC      = 2;
    localparam int LINE_CYCLES = H_BACK + FRAME_W + H_SYNC;
    localparam int NUM_FRAMES  = 80;
    localparam int RESET_FRAME = 60;

    logic       clk = 1'b0;
    logic       rst_i;
    logic       cen_i;
    logic       fast_i;
    logic [1:0] vh_blank_i;
    logic [2:0] dvh_sync_i;
    logic [2:0] dvh_sync_o;
    rgb_t       vid_rgb_o;
    integer     seed;

    `include "tb_scene_model.svh"

    pipe_scene_top #(
        .FRAME_W       (FRAME_W),
        .FRAME_H       (FRAME_H),
        .NUM_PIPES     (NUM_PIPES),
        .PIPE_WIDTH    (PIPE_WIDTH),
        .GAP_HEIGHT    (GAP_HEIGHT),
        .GAP_MARGIN    (GAP_MARGIN),
        .PIPE_SPACING  (PIPE_SPACING),
        .START_OFFSET  (START_OFFSET),
        .SPEED_SLOW    (SPEED_SLOW),
        .SPEED_FAST    (SPEED_FAST),
        .RAND_BITS     (RAND_BITS),
        .GRASS_HEIGHT  (GRASS_HEIGHT),
        .GROUND_HEIGHT (GROUND_HEIGHT),
        .GAP_INIT      (GAP_INIT)
    ) u_pipe_scene_top (
        .clk        (clk),
        .rst_i      (rst_i),
        .cen_i      (cen_i),
        .fast_i     (fast_i),
        .vh_blank_i (vh_blank_i),
        .dvh_sync_i (dvh_sync_i),
        .dvh_sync_o (dvh_sync_o),
        .vid_rgb_o  (vid_rgb_o)
    );

    always #2 clk = ~clk;

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
            $display("RESULT: FAIL");
            $fatal(1, "output mismatch");
        end
    endtask

    // --------------------
    // Per-cycle driver
    // --------------------
    // Model follows the rising edge, outputs are checked on the falling one
    task automatic tick(input logic [1:0] blank, input logic [2:0] sync);
        @(posedge clk);
        model_clock(rst_i, cen_i, fast_i, vh_blank_i, dvh_sync_i);
        @(negedge clk);
        check_value("dvh_sync_o", 32'(dvh_sync_o), 32'(exp_sync));
        check_value("vid_rgb_o", 32'(vid_rgb_o), 32'(exp_rgb));
        // Enable drops about one cycle in eight
        cen_i      = (($random(seed) & 7) != 0);
        vh_blank_i = blank;
        dvh_sync_i = sync;
    endtask

    task automatic run_line(input logic vs, input logic act);
        logic hblank;
        logic hs;
        for (int c = 0; c < LINE_CYCLES; c++) begin
            hblank = (c < H_BACK) || (c >= H_BACK + FRAME_W);
            hs     = !vs && (c >= LINE_CYCLES - H_SYNC);
            tick({!act, hblank}, {act && !hblank, vs, hs});
        end
    endtask

    // Vsync line first, then the picture, cut short when lines is small
    task automatic run_frame(input int lines);
        if (($random(seed) & 3) == 0) begin
            fast_i = ~fast_i;
        end
        for (int l = 0; l < lines; l++) begin
            run_line(l == 0, l != 0);
        end
    endtask

    // Outputs are compared against the cleared model on every reset cycle
    task automatic apply_reset();
        rst_i = 1'b1;
        for (int n = 0; n < 5; n++) begin
            tick(2'b11, 3'b000);
        end
        rst_i = 1'b0;
    endtask

    initial begin
        seed       = 32'h14d4;
        rst_i      = 1'b1;
        cen_i      = 1'b0;
        fast_i     = 1'b0;
        vh_blank_i = 2'b11;
        dvh_sync_i = 3'b000;
        apply_reset();
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f == RESET_FRAME) begin
                // Reset halfway down a picture
                run_frame(FRAME_H / 2);
                apply_reset();
            end
            run_frame(FRAME_H + 1);
        end
        if (wraps_seen > 0 && pipe_pixels_seen > 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("Run too short, no pipe pixel or no pipe wrap was seen");
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+testbench
hdl/pipe_scene_pkg.sv
hdl/raster_counter.sv
hdl/pipe_scroller.sv
hdl/pixel_composer.sv
hdl/pipe_scene_top.sv
testbench/pipe_scene_sva.sv
testbench/tb_pipe_scene.sv
